// ==== core_port_sequencer.sv ====
// ====================
// load walks col, row, comp, core; drain walks col, row, core with one read in flight
// ====================
`timescale 1ns/1ps

module core_port_sequencer (
	input  logic                   proc_clk,
	input  logic                   full_reset,
	input  pmk_geom_pkg::mode_t    mode,
	input  logic [31:0]            fetch_word,
	input  logic                   fetch_valid,
	input  logic                   write_accepted,
	input  pmk_bus_pkg::core_rsp_t core_rsp,
	output pmk_bus_pkg::core_req_t core_req,
	output logic [31:0]            result_word,
	output logic                   result_valid,
	output logic                   load_complete,
	output logic                   queued_request,
	output logic [31:0]            loaded_count,
	output logic [31:0]            drained_count
);

	// ====================
	// load walk
	logic [3:0] wr_inst;
	logic [1:0] wr_comp;
	logic [7:0] wr_row;
	logic [2:0] wr_col;
	logic [8:0] wr_row_field; // comp 2 sits above comp 1 rows
	logic       core_full;    // all input words written

	// drain walk
	logic [3:0] rd_inst;
	logic [7:0] rd_row;
	logic [2:0] rd_col;
	logic       core_empty;   // all result reads issued

	assign wr_row_field = (wr_comp == 2'd2) ?
		9'(wr_row) + 9'(pmk_geom_pkg::jobs_per_core) : 9'(wr_row);
	assign result_word = core_rsp.data_out;
	assign result_valid = core_rsp.readdatavalid && (mode == pmk_geom_pkg::mode_drain);

	always_ff @(posedge proc_clk)
	begin
		if (full_reset)
		begin
			core_req.wren <= 1'b0;
			core_req.rden <= 1'b0;
			load_complete <= 1'b0;
			queued_request <= 1'b0;
			loaded_count <= '0;
			drained_count <= '0;
			core_full <= 1'b0;
			core_empty <= 1'b0;
			{wr_inst, wr_comp, wr_row, wr_col} <= '0;
			{rd_inst, rd_row, rd_col} <= '0;
		end
		else
		begin
			if ((mode == pmk_geom_pkg::mode_load) && fetch_valid && !core_full)
			begin
				core_req.data_in <= fetch_word;
				core_req.wren <= 1'b1;
				core_req.addr <= {wr_inst, (wr_comp != 2'd0), wr_row_field, wr_col};
				loaded_count <= loaded_count + 32'd1;
				if (wr_col != 3'(pmk_geom_pkg::words_per_row - 1))
					wr_col <= wr_col + 3'd1;
				else
				begin
					wr_col <= '0;
					if (wr_row != 8'(pmk_geom_pkg::jobs_per_core - 1))
						wr_row <= wr_row + 8'd1;
					else
					begin
						wr_row <= '0;
						if (wr_comp != 2'(pmk_geom_pkg::num_comps - 1))
							wr_comp <= wr_comp + 2'd1;
						else
						begin
							wr_comp <= '0;
							wr_inst <= wr_inst + 4'd1; // next core
						end
					end
				end
				core_full <= (loaded_count == 32'(pmk_geom_pkg::words_in - 1));
				load_complete <= (loaded_count == 32'(pmk_geom_pkg::words_in - 1));
			end
			else
			begin
				core_req.wren <= 1'b0;
				load_complete <= 1'b0; // single pulse
			end

			if ((mode == pmk_geom_pkg::mode_drain) && !core_empty && !queued_request)
			begin
				queued_request <= 1'b1; // held until ddr takes the write
				core_req.rden <= 1'b1;
				core_req.addr <= 17'(rd_inst * pmk_geom_pkg::core_inst_stride
					+ rd_row * pmk_geom_pkg::row_stride + rd_col);
				drained_count <= drained_count + 32'd1;
				core_empty <= (drained_count == 32'(pmk_geom_pkg::words_out - 1));
				if (rd_col != 3'(pmk_geom_pkg::words_per_row - 1))
					rd_col <= rd_col + 3'd1;
				else
				begin
					rd_col <= '0;
					if (rd_row != 8'(pmk_geom_pkg::jobs_per_core - 1))
						rd_row <= rd_row + 8'd1;
					else
					begin
						rd_row <= '0;
						rd_inst <= rd_inst + 4'd1;
					end
				end
			end
			else
				core_req.rden <= 1'b0;
			if (write_accepted)
				queued_request <= 1'b0;

			// restart clears both walks
			if (mode == pmk_geom_pkg::mode_restart)
			begin
				queued_request <= 1'b0;
				loaded_count <= '0;
				drained_count <= '0;
				core_full <= 1'b0;
				core_empty <= 1'b0;
				{wr_inst, wr_comp, wr_row, wr_col} <= '0;
				{rd_inst, rd_row, rd_col} <= '0;
			end
		end
	end

endmodule

// ==== ddr_bridge_master.sv ====
// ====================
// one master for both regions; at most one result write outstanding
// ====================
`timescale 1ns/1ps

module ddr_bridge_master (
	input  logic                   proc_clk,
	input  logic                   full_reset,
	input  pmk_geom_pkg::mode_t    mode,
	input  logic                   restart_pending,
	input  pmk_bus_pkg::ddr_rsp_t  ddr_rsp,
	input  logic [31:0]            result_word,
	input  logic                   result_valid,
	output pmk_bus_pkg::ddr_req_t  ddr_req,
	output logic [31:0]            fetch_word,
	output logic                   fetch_valid,
	output logic                   write_accepted,
	output logic [26:0]            read_ptr,
	output logic [26:0]            write_ptr,
	output logic [31:0]            fetched_count,
	output logic                   source_exhausted
);

	logic source_empty;   // all input words of the batch requested
	logic result_pending; // result arrived under waitrequest

	assign fetch_word = ddr_rsp.readdata;
	assign fetch_valid = ddr_rsp.readdatavalid && (mode == pmk_geom_pkg::mode_load);
	assign write_accepted = ddr_req.write && !ddr_rsp.waitrequest; // frees the next core read

	always_ff @(posedge proc_clk)
	begin
		if (full_reset)
		begin
			ddr_req.read <= 1'b0;
			ddr_req.write <= 1'b0;
			ddr_req.burstcount <= '0;
			read_ptr <= '0;
			write_ptr <= '0;
			fetched_count <= '0;
			source_empty <= 1'b0;
			source_exhausted <= 1'b0;
			result_pending <= 1'b0;
		end
		else
		begin
			source_exhausted <= {5'b0, read_ptr} >= 32'(pmk_geom_pkg::src_limit_bytes);
			case (mode)
			pmk_geom_pkg::mode_load:
			begin
				ddr_req.write <= 1'b0;
				if (!source_empty && !ddr_rsp.waitrequest)
				begin
					ddr_req.read <= 1'b1; // next burst, previous one accepted
					ddr_req.burstcount <= 3'(pmk_geom_pkg::burst_len);
					ddr_req.address <= pmk_geom_pkg::src_offset + {5'b0, read_ptr};
					read_ptr <= read_ptr + 27'(pmk_geom_pkg::burst_len * 4);
					fetched_count <= fetched_count + 32'(pmk_geom_pkg::burst_len);
					source_empty <= (fetched_count ==
						32'(pmk_geom_pkg::words_in - pmk_geom_pkg::burst_len));
				end
				else if (!ddr_rsp.waitrequest)
					ddr_req.read <= 1'b0; // last burst taken
			end
			pmk_geom_pkg::mode_drain:
			begin
				ddr_req.read <= 1'b0;
				if (result_valid)
					ddr_req.writedata <= result_word; // safe, only one in flight
				if (!ddr_rsp.waitrequest)
				begin
					if (result_valid || result_pending)
					begin
						ddr_req.write <= 1'b1;
						ddr_req.burstcount <= 3'd1;
						ddr_req.address <= pmk_geom_pkg::dst_offset + {5'b0, write_ptr};
						write_ptr <= write_ptr + 27'd4;
						result_pending <= 1'b0;
					end
					else
						ddr_req.write <= 1'b0;
				end
				else if (result_valid)
					result_pending <= 1'b1; // bus busy, send when it frees
			end
			pmk_geom_pkg::mode_restart:
			begin
				ddr_req.read <= 1'b0;
				ddr_req.write <= 1'b0;
				fetched_count <= '0;
				source_empty <= 1'b0;
				source_exhausted <= 1'b0;
				result_pending <= 1'b0;
				if (restart_pending)
				begin
					read_ptr <= '0; // host restart only, batch end keeps going
					write_ptr <= '0;
				end
			end
			default:
			begin
				ddr_req.read <= 1'b0; // run, bus idle
				ddr_req.write <= 1'b0;
			end
			endcase
		end
	end

endmodule

// ==== job_mode_ctrl.sv ====
// ====================
// host restart = any change of word 3 nibble; pointers cleared only then
// ====================
`timescale 1ns/1ps

module job_mode_ctrl (
	input  logic                       proc_clk,
	input  logic                       full_reset,
	input  pmk_bus_pkg::status_words_t host_words,
	input  logic                       load_complete,
	input  logic                       core_done,
	input  logic [31:0]                drained_count,
	input  logic                       source_exhausted,
	input  logic [26:0]                read_ptr,
	input  logic [26:0]                write_ptr,
	input  logic [31:0]                fetched_count,
	input  logic [31:0]                loaded_count,
	input  logic                       queued_request,
	input  pmk_bus_pkg::ddr_req_t      ddr_req,
	input  pmk_bus_pkg::ddr_rsp_t      ddr_rsp,
	output pmk_geom_pkg::mode_t        mode,
	output logic                       restart_pending,
	output pmk_bus_pkg::status_words_t local_words
);

	logic [3:0]  reset_count;  // last seen host nibble
	logic        load_done_d;  // load_complete, one cycle late
	logic [63:0] cycle_count;
	logic [63:0] run_count;    // cycles in mode_run
	logic [3:0]  host_nibble;

	assign host_nibble = host_words[pmk_geom_pkg::sw_reset_req][3:0];

	always_ff @(posedge proc_clk)
	begin
		if (full_reset)
		begin
			mode <= pmk_geom_pkg::mode_load;
			restart_pending <= 1'b0;
			reset_count <= '0;
			load_done_d <= 1'b0;
			cycle_count <= '0;
			run_count <= '0;
		end
		else
		begin
			cycle_count <= cycle_count + 64'd1;
			if (mode == pmk_geom_pkg::mode_run)
				run_count <= run_count + 64'd1;
			load_done_d <= load_complete;
			if (host_nibble != reset_count)
			begin
				restart_pending <= 1'b1; // host request, from any mode
				reset_count <= host_nibble;
				mode <= pmk_geom_pkg::mode_restart;
			end
			else
			begin
				case (mode)
				pmk_geom_pkg::mode_load:
					if (load_done_d)
						mode <= pmk_geom_pkg::mode_run;
				pmk_geom_pkg::mode_run:
					if (core_done)
						mode <= pmk_geom_pkg::mode_drain;
				pmk_geom_pkg::mode_drain:
					if ((drained_count == 32'(pmk_geom_pkg::words_out)) && !queued_request
						&& !source_exhausted)
						mode <= pmk_geom_pkg::mode_restart; // next batch, pointers run on
				default:
				begin
					restart_pending <= 1'b0; // restart lasts one cycle
					mode <= pmk_geom_pkg::mode_load;
				end
				endcase
			end
		end
	end

	// ====================
	// local status image
	always_comb
	begin
		local_words = '0;
		local_words[pmk_geom_pkg::sw_write_ptr] = {5'b0, write_ptr};
		local_words[pmk_geom_pkg::sw_read_ptr] = {5'b0, read_ptr};
		local_words[pmk_geom_pkg::sw_flags] = {24'b0, queued_request, mode, 1'b0,
			ddr_rsp.waitrequest, 1'b0, ddr_req.read, ddr_req.write}; // dispatcher bits zero
		local_words[pmk_geom_pkg::sw_cycles] = cycle_count[31:0];
		local_words[pmk_geom_pkg::sw_cycles + 1] = cycle_count[63:32];
		local_words[pmk_geom_pkg::sw_run_cycles] = run_count[31:0];
		local_words[pmk_geom_pkg::sw_run_cycles + 1] = run_count[63:32];
		local_words[pmk_geom_pkg::sw_fetched] = fetched_count;
		local_words[pmk_geom_pkg::sw_loaded] = loaded_count;
		local_words[pmk_geom_pkg::sw_drained] = drained_count;
		local_words[pmk_geom_pkg::sw_reset_count] = {28'b0, reset_count};
	end

endmodule

// ==== pmk_bus_pkg.sv ====
// ====================
// bus bundles; byteenable and debugaccess are not carried, always all lanes
// ====================
package pmk_bus_pkg;

	// ====================
	// ddr master, held while waitrequest is high
	typedef struct packed {
		logic        read;       // burst read strobe
		logic        write;      // single word write strobe
		logic [31:0] address;    // byte address
		logic [2:0]  burstcount; // 4 for reads, 1 for writes
		logic [31:0] writedata;
	} ddr_req_t;

	typedef struct packed {
		logic        waitrequest;   // stall, hold request
		logic [31:0] readdata;
		logic        readdatavalid; // one pulse per word, in order
	} ddr_rsp_t;

	// ====================
	// compute core port, no back-pressure
	typedef struct packed {
		logic [16:0] addr;    // core | comp | row | col
		logic        rden;    // one cycle strobe
		logic        wren;    // one cycle strobe
		logic [31:0] data_in;
	} core_req_t;

	typedef struct packed {
		logic [31:0] data_out;
		logic        readdatavalid; // one cycle after rden
		logic        done;          // level, batch finished
	} core_rsp_t;

	// ====================
	// host status port, never stalls
	typedef struct packed {
		logic        read;
		logic        write;
		logic [7:0]  address;   // word address
		logic [31:0] writedata;
	} mmio_req_t;

	typedef struct packed {
		logic [31:0] readdata;
		logic        readdatavalid; // 3 cycles after read
	} mmio_rsp_t;

	// whole status image, word i at [i]
	typedef logic [pmk_geom_pkg::status_words-1:0][31:0] status_words_t;

endpackage

// ==== pmk_feeder.f ====
pmk_geom_pkg.sv
pmk_bus_pkg.sv
status_regfile.sv
ddr_bridge_master.sv
core_port_sequencer.sv
job_mode_ctrl.sv
pmk_feeder_top.sv
tb_pmk_feeder.sv

// ==== pmk_feeder_top.sv ====
// ====================
// feeder logic only; host bus, ddr master and core port come from outside
// ====================
`timescale 1ns/1ps

module pmk_feeder_top (
	input  logic                   proc_clk,
	input  logic                   full_reset,
	input  pmk_bus_pkg::mmio_req_t mmio_req,
	input  pmk_bus_pkg::ddr_rsp_t  ddr_rsp,
	input  pmk_bus_pkg::core_rsp_t core_rsp,
	output pmk_bus_pkg::mmio_rsp_t mmio_rsp,
	output pmk_bus_pkg::ddr_req_t  ddr_req,
	output pmk_bus_pkg::core_req_t core_req
);

	pmk_geom_pkg::mode_t        mode;
	logic                       restart_pending;
	pmk_bus_pkg::status_words_t local_words;
	pmk_bus_pkg::status_words_t host_words;
	logic [31:0]                fetch_word;    // ddr -> core
	logic                       fetch_valid;
	logic [31:0]                result_word;   // core -> ddr
	logic                       result_valid;
	logic                       write_accepted;
	logic                       load_complete;
	logic                       queued_request;
	logic                       source_exhausted;
	logic [26:0]                read_ptr;
	logic [26:0]                write_ptr;
	logic [31:0]                fetched_count;
	logic [31:0]                loaded_count;
	logic [31:0]                drained_count;

	status_regfile #(.local_mask(pmk_geom_pkg::status_local_mask)) status_i (.*);

	ddr_bridge_master ddr_i (.*);

	core_port_sequencer core_seq_i (.*);

	job_mode_ctrl mode_i (
		.*,
		.core_done(core_rsp.done)
	);

endmodule

// ==== pmk_geom_pkg.sv ====
// ====================
// batch geometry is fixed at build time; core side assumes 4 cores x 120 rows
// ====================
package pmk_geom_pkg;

	// ====================
	// batch geometry
	localparam int num_cores     = 4;   // compute cores behind the port
	localparam int jobs_per_core = 120; // rows per component
	localparam int num_comps     = 3;   // components per job
	localparam int words_per_row = 5;   // columns
	localparam int words_in      = num_cores * jobs_per_core * num_comps * words_per_row;
	localparam int words_out     = num_cores * jobs_per_core * words_per_row;
	localparam int burst_len     = 4;   // words per ddr read burst

	// ====================
	// address mapping
	localparam logic [31:0] src_offset = 32'h2000_0000; // input region base
	localparam logic [31:0] dst_offset = 32'h2800_0000; // result region base
	localparam int src_limit_bytes     = jobs_per_core * num_cores * 60 * 1000;
	localparam int core_inst_stride    = 8192;          // one core per 8k words
	localparam int row_stride          = 8;             // column field is 3 bits

	// ====================
	// status window
	localparam int status_words = 32;
	localparam logic [status_words-1:0] status_local_mask = 32'h0003_ffc7; // 0-2, 6-17
	localparam int sw_write_ptr   = 0;  // result pointer
	localparam int sw_read_ptr    = 1;  // source pointer
	localparam int sw_flags       = 2;  // bus flags and mode
	localparam int sw_reset_req   = 3;  // host owned, nibble 3:0
	localparam int sw_cycles      = 6;  // 64 bit, words 6-7
	localparam int sw_run_cycles  = 8;  // 64 bit, words 8-9
	localparam int sw_fetched     = 10;
	localparam int sw_loaded      = 11;
	localparam int sw_drained     = 12;
	localparam int sw_reset_count = 13;

	typedef enum logic [1:0] {
		mode_load    = 2'd0, // ddr -> core
		mode_run     = 2'd1, // wait for done
		mode_drain   = 2'd2, // core -> ddr
		mode_restart = 2'd3  // one cycle clear
	} mode_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; the result is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_pmk_feeder -f pmk_feeder.f -o tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && echo "RESULT: FAIL" && exit 1 \
	|| echo "RESULT: PASS"
exit 0

// ==== status_regfile.sv ====
// ====================
// reads take 3 cycles, writes land 2 cycles after strobe; masked words ignore host writes
// ====================
`timescale 1ns/1ps

module status_regfile #(
	parameter logic [31:0] local_mask = 32'h0 // set bit = word owned by local status
) (
	input  logic                       proc_clk,
	input  logic                       full_reset,
	input  pmk_bus_pkg::mmio_req_t     mmio_req,
	input  pmk_bus_pkg::status_words_t local_words,
	output pmk_bus_pkg::mmio_rsp_t     mmio_rsp,
	output pmk_bus_pkg::status_words_t host_words
);

	localparam int n_words = $bits(pmk_bus_pkg::status_words_t) / 32;

	pmk_bus_pkg::status_words_t storage;
	logic        wr_req;      // registered host write
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic        rd_stg1;     // read strobe, stage 1
	logic        rd_stg2;     // read strobe, stage 2
	logic [4:0]  rd_addr1;
	logic [2:0]  rd_addr2;    // group select for final mux
	logic [31:0] part_rsp [8]; // one candidate per group of 4

	assign host_words = storage;

	always_ff @(posedge proc_clk)
	begin
		if (full_reset)
		begin
			wr_req <= 1'b0;
			rd_stg1 <= 1'b0;
			rd_stg2 <= 1'b0;
			mmio_rsp.readdatavalid <= 1'b0;
			storage <= '0; // host nibble must start at 0
		end
		else
		begin
			wr_req <= mmio_req.write && (mmio_req.address < 8'(n_words)); // out of range dropped
			for (int i = 0; i < n_words; i++)
			begin
				if (local_mask[i])
					storage[i] <= local_words[i]; // local status wins every cycle
				else if (wr_req && (wr_addr == 5'(i)))
					storage[i] <= wr_data;
			end
			rd_stg1 <= mmio_req.read;
			rd_stg2 <= rd_stg1;
			mmio_rsp.readdatavalid <= rd_stg2;
		end
	end

	// read data path, no reset
	always_ff @(posedge proc_clk)
	begin
		wr_addr <= mmio_req.address[4:0];
		wr_data <= mmio_req.writedata;
		rd_addr1 <= mmio_req.address[4:0];
		for (int g = 0; g < 8; g++)
			part_rsp[g] <= storage[{3'(g), rd_addr1[1:0]}]; // 8-way preselect on low bits
		rd_addr2 <= rd_addr1[4:2];
		mmio_rsp.readdata <= part_rsp[rd_addr2]; // final select
	end

endmodule

// ==== tb_pmk_feeder.sv ====
// ====================
// ddr and core are models here; two batches then a host restart with the bus held off
// ====================
`timescale 1ns/1ps

module tb_pmk_feeder;

	localparam int cycle_limit = 100000; // two batches take about 40000

	logic proc_clk;
	logic full_reset;
	logic host_rd, host_wr;              // host bus drive
	logic [7:0] host_addr;
	logic [31:0] host_wdata;
	logic ddr_wait, ddr_rvalid;          // ddr model drive
	logic [31:0] ddr_rdata;
	logic core_rvalid, core_done_lvl;    // core model drive
	logic [31:0] core_rdata;
	pmk_bus_pkg::mmio_req_t mmio_req;
	pmk_bus_pkg::mmio_rsp_t mmio_rsp;
	pmk_bus_pkg::ddr_req_t  ddr_req;
	pmk_bus_pkg::ddr_rsp_t  ddr_rsp;
	pmk_bus_pkg::core_req_t core_req;
	pmk_bus_pkg::core_rsp_t core_rsp;

	logic [31:0] core_mem [0:131071];    // core model storage
	logic [31:0] rd_queue [$];           // burst addresses still to return
	logic rd_pend;
	logic [16:0] rd_addr;
	logic hold_wait;                     // forces waitrequest high
	logic reads_allowed;                 // done has risen this batch
	int cycles, value_errors, other_errors;
	int src_idx, core_writes, ddr_writes;

	assign mmio_req = {host_rd, host_wr, host_addr, host_wdata};
	assign ddr_rsp = {ddr_wait, ddr_rdata, ddr_rvalid};
	assign core_rsp = {core_rdata, core_rvalid, core_done_lvl};

	pmk_feeder_top dut_i (.*);

	initial
	begin
		proc_clk = 1'b0;
		forever #10 proc_clk = ~proc_clk; // 20 ns
	end

	// ====================
	// checks
	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act)
		else
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	function automatic logic [16:0] load_addr(input int i);
		int col, row, comp, core;
		col = i % 5;
		row = (i / 5) % 120;
		comp = (i / 600) % 3;
		core = i / 1800;
		return 17'(core * 8192 + (comp != 0 ? 4096 : 0) + (row + (comp == 2 ? 120 : 0)) * 8 + col);
	endfunction

	function automatic logic [16:0] drain_addr(input int j);
		return 17'((j / 600) * 8192 + ((j / 5) % 120) * 8 + j % 5);
	endfunction

	rden_after_done: assert property (@(posedge proc_clk) core_req.rden |-> reads_allowed)
	else
	begin
		other_errors++;
		$display("core read started before done was raised");
	end

	// ====================
	// ddr and core models
	always @(posedge proc_clk)
	begin
		cycles++;
		if (!full_reset && ddr_req.read && !ddr_wait)
		begin
			check_word("read burstcount", 32'd4, 32'(ddr_req.burstcount));
			for (int k = 0; k < 4; k++)
				rd_queue.push_back(ddr_req.address + 32'(4 * k)); // accepted burst
		end
		if (!full_reset && ddr_req.write && !ddr_wait)
		begin
			check_word("drain burstcount", 32'd1, 32'(ddr_req.burstcount));
			check_word("drain address", pmk_geom_pkg::dst_offset + 32'(4 * ddr_writes),
				ddr_req.address);
			check_word("drain data", core_mem[drain_addr(ddr_writes % 2400)] ^ 32'hffff_0000,
				ddr_req.writedata);
			ddr_writes++;
		end
		if (core_req.wren)
		begin
			check_word("load address", load_addr(core_writes % 7200), 32'(core_req.addr));
			check_word("load data", (pmk_geom_pkg::src_offset + 32'(4 * src_idx)) ^ 32'h5a5a_5a5a,
				core_req.data_in);
			core_mem[core_req.addr] = core_req.data_in;
			src_idx++; // source stream continues across batches
			core_writes++;
		end
		rd_pend = core_req.rden;
		rd_addr = core_req.addr;
	end

	always @(negedge proc_clk)
	begin
		ddr_wait <= hold_wait || ($urandom % 4 == 0); // random stall
		if (rd_queue.size() > 0)
		begin
			ddr_rvalid <= 1'b1;
			ddr_rdata <= rd_queue.pop_front() ^ 32'h5a5a_5a5a;
		end
		else
			ddr_rvalid <= 1'b0;
		core_rvalid <= rd_pend; // one cycle after rden
		core_rdata <= core_mem[rd_addr] ^ 32'hffff_0000;
	end

	always @(negedge proc_clk)
		if (cycles >= cycle_limit)
		begin
			other_errors++;
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("errors: value %0d, other %0d", value_errors, other_errors);
			$display("sim failed");
			$finish;
		end

	// ====================
	// host bus
	task automatic host_write(input logic [4:0] a, input logic [31:0] d);
		host_wr = 1'b1;
		host_addr = {3'b0, a};
		host_wdata = d;
		@(negedge proc_clk);
		host_wr = 1'b0;
	endtask

	task automatic host_read(input logic [4:0] a, output logic [31:0] d);
		int lat;
		host_rd = 1'b1;
		host_addr = {3'b0, a};
		@(negedge proc_clk);
		host_rd = 1'b0;
		lat = 1;
		while (!mmio_rsp.readdatavalid && lat < 8)
		begin
			@(negedge proc_clk);
			lat++;
		end
		check_word("read latency", 32'd3, 32'(lat));
		d = mmio_rsp.readdata;
	endtask

	task automatic wait_for_run;
		logic [31:0] w;
		w = '0;
		while (w[6:5] != 2'd1) // mode field of word 2
			host_read(5'd2, w);
	endtask

	// ====================
	// stimulus
	initial
	begin
		logic [31:0] val, rd, lo, hi;
		void'($urandom(32'hb1f70f2c));
		{host_rd, host_wr, host_addr, host_wdata} = '0;
		{ddr_wait, ddr_rvalid, ddr_rdata} = '0;
		{core_rvalid, core_done_lvl, core_rdata} = '0;
		{rd_pend, rd_addr, reads_allowed} = '0;
		hold_wait = 1'b1; // keep pointers at zero for the status test
		{cycles, value_errors, other_errors, src_idx, core_writes, ddr_writes} = '0;
		full_reset = 1'b1;
		repeat (5) @(posedge proc_clk);
		@(negedge proc_clk);
		full_reset = 1'b0;

		val = $urandom;
		host_write(5'd20, val);
		host_read(5'd20, rd);
		check_word("status word 20", val, rd);
		host_write(5'd1, 32'hdead_0001); // local word, write is lost
		repeat (3) @(negedge proc_clk);
		host_read(5'd1, rd);
		check_word("status word 1 local", 32'd0, rd);
		hold_wait = 1'b0;

		// batch 1
		wait_for_run();
		check_word("loaded before run", 32'd7200, 32'(core_writes));
		repeat (20 + $urandom % 41) @(negedge proc_clk);
		core_done_lvl = 1'b1;
		reads_allowed = 1'b1;
		while (ddr_writes == 0)
			@(negedge proc_clk);
		core_done_lvl = 1'b0;
		while (ddr_writes < 2400)
			@(negedge proc_clk);
		reads_allowed = 1'b0;

		// batch 2 runs on from the old source pointer
		wait_for_run();
		check_word("loaded batch 2", 32'd14400, 32'(core_writes));
		check_word("writes batch 1", 32'd2400, 32'(ddr_writes));
		host_read(5'd8, lo);
		host_read(5'd9, hi);
		assert ({hi, lo} != 64'd0)
		else
		begin
			other_errors++;
			$display("run count in words 8-9 is still zero");
		end

		// host restart while the bus is held off
		hold_wait = 1'b1;
		host_write(5'd3, 32'd1);
		repeat (10) @(negedge proc_clk);
		host_read(5'd0, rd);
		check_word("write pointer after restart", 32'd0, rd);
		host_read(5'd1, rd);
		check_word("read pointer after restart", 32'd0, rd);
		host_read(5'd13, rd);
		check_word("reset count", 32'd1, rd);

		$display("errors: value %0d, other %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
